// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert
TB_TOP     ?= tb_spatz
RTL_TOP    ?= spatz
FILELIST   ?= spatz.f
OBJ_DIR    ?= obj_dir
PASS_TEXT  := Result: PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TB_TOP)
	@out="$$(./$(OBJ_DIR)/$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: spatz.f
+incdir+.
spatz_pkg.sv
spatz_controller.sv
spatz_vrf.sv
spatz_vfu.sv
spatz_vlsu.sv
spatz.sv
tb_spatz.sv

// File: spatz.sv
`timescale 1ns/1ns
`include "spatz_params.svh"

/*
 * Coprocessor top: controller, register file, functional unit
 * and load/store unit
 */
module spatz (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Issue
  input  logic                  x_issue_valid_i,
  output logic                  x_issue_ready_o,
  input  spatz_pkg::op_e        x_issue_op_i,
  input  spatz_pkg::vreg_addr_t x_issue_vd_i,
  input  spatz_pkg::vreg_addr_t x_issue_vs1_i,
  input  spatz_pkg::vreg_addr_t x_issue_vs2_i,
  input  spatz_pkg::addr_t      x_issue_addr_i,
  // Result
  output logic                  x_result_valid_o,
  input  logic                  x_result_ready_i,
  output spatz_pkg::tag_t       x_result_tag_o,
  // Memory
  output logic                  x_mem_valid_o,
  input  logic                  x_mem_ready_i,
  output spatz_pkg::addr_t      x_mem_addr_o,
  output logic                  x_mem_we_o,
  output spatz_pkg::elem_t      x_mem_wdata_o,
  input  logic                  x_mem_result_valid_i,
  input  spatz_pkg::elem_t      x_mem_result_i,
  output logic                  x_mem_finished_o
);
  import spatz_pkg::*;

  // Request bus
  logic       req_valid;
  op_e        req_op;
  vreg_addr_t req_vd;
  vreg_addr_t req_vs1;
  vreg_addr_t req_vs2;
  addr_t      req_addr;
  tag_t       req_tag;

  logic       vfu_req_ready;
  logic       vfu_rsp_valid;
  tag_t       vfu_rsp_tag;
  vreg_addr_t vfu_rsp_vd;
  logic       vlsu_req_ready;
  logic       vlsu_rsp_valid;
  tag_t       vlsu_rsp_tag;
  vreg_addr_t vlsu_rsp_vd;

  // Write port 0 and read ports 0..1 belong to the VFU
  vreg_addr_t [1:0] vrf_waddr;
  vreg_data_t [1:0] vrf_wdata;
  vreg_be_t   [1:0] vrf_wbe;
  vreg_addr_t [2:0] vrf_raddr;
  logic       [2:0] vrf_re;
  vreg_data_t [2:0] vrf_rdata;

  spatz_controller i_controller (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .x_issue_valid_i (x_issue_valid_i),
    .x_issue_ready_o (x_issue_ready_o),
    .x_issue_op_i    (x_issue_op_i),
    .x_issue_vd_i    (x_issue_vd_i),
    .x_issue_vs1_i   (x_issue_vs1_i),
    .x_issue_vs2_i   (x_issue_vs2_i),
    .x_issue_addr_i  (x_issue_addr_i),
    .x_result_valid_o(x_result_valid_o),
    .x_result_ready_i(x_result_ready_i),
    .x_result_tag_o  (x_result_tag_o),
    .req_valid_o     (req_valid),
    .req_op_o        (req_op),
    .req_vd_o        (req_vd),
    .req_vs1_o       (req_vs1),
    .req_vs2_o       (req_vs2),
    .req_addr_o      (req_addr),
    .req_tag_o       (req_tag),
    .vfu_req_ready_i (vfu_req_ready),
    .vlsu_req_ready_i(vlsu_req_ready),
    .vfu_rsp_valid_i (vfu_rsp_valid),
    .vfu_rsp_tag_i   (vfu_rsp_tag),
    .vfu_rsp_vd_i    (vfu_rsp_vd),
    .vlsu_rsp_valid_i(vlsu_rsp_valid),
    .vlsu_rsp_tag_i  (vlsu_rsp_tag),
    .vlsu_rsp_vd_i   (vlsu_rsp_vd)
  );

  spatz_vrf #(
    .NR_WRITE_PORTS(2),
    .NR_READ_PORTS (3)
  ) i_vrf (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .waddr_i(vrf_waddr),
    .wdata_i(vrf_wdata),
    .wbe_i  (vrf_wbe),
    .raddr_i(vrf_raddr),
    .re_i   (vrf_re),
    .rdata_o(vrf_rdata)
  );

  spatz_vfu i_vfu (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_valid_i(req_valid),
    .req_op_i   (req_op),
    .req_vd_i   (req_vd),
    .req_vs1_i  (req_vs1),
    .req_vs2_i  (req_vs2),
    .req_tag_i  (req_tag),
    .req_ready_o(vfu_req_ready),
    .rsp_valid_o(vfu_rsp_valid),
    .rsp_tag_o  (vfu_rsp_tag),
    .rsp_vd_o   (vfu_rsp_vd),
    .vrf_waddr_o(vrf_waddr[0]),
    .vrf_wdata_o(vrf_wdata[0]),
    .vrf_wbe_o  (vrf_wbe[0]),
    .vrf_raddr_o(vrf_raddr[1:0]),
    .vrf_re_o   (vrf_re[1:0]),
    .vrf_rdata_i(vrf_rdata[1:0])
  );

  spatz_vlsu i_vlsu (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .req_valid_i         (req_valid),
    .req_op_i            (req_op),
    .req_vd_i            (req_vd),
    .req_addr_i          (req_addr),
    .req_tag_i           (req_tag),
    .req_ready_o         (vlsu_req_ready),
    .rsp_valid_o         (vlsu_rsp_valid),
    .rsp_tag_o           (vlsu_rsp_tag),
    .rsp_vd_o            (vlsu_rsp_vd),
    .vrf_waddr_o         (vrf_waddr[1]),
    .vrf_wdata_o         (vrf_wdata[1]),
    .vrf_wbe_o           (vrf_wbe[1]),
    .vrf_raddr_o         (vrf_raddr[2]),
    .vrf_re_o            (vrf_re[2]),
    .vrf_rdata_i         (vrf_rdata[2]),
    .x_mem_valid_o       (x_mem_valid_o),
    .x_mem_ready_i       (x_mem_ready_i),
    .x_mem_addr_o        (x_mem_addr_o),
    .x_mem_we_o          (x_mem_we_o),
    .x_mem_wdata_o       (x_mem_wdata_o),
    .x_mem_result_valid_i(x_mem_result_valid_i),
    .x_mem_result_i      (x_mem_result_i),
    .x_mem_finished_o    (x_mem_finished_o)
  );

  ////////////////////
  // Elaboration checks
  ////////////////////

  if (`SPATZ_VLEN != 2 ** $clog2(`SPATZ_VLEN)) begin : g_vlen_check
    $error("Elements per vector must be a power of two");
  end

  if (`SPATZ_ELEN > 32) begin : g_elen_check
    $error("Element width must not exceed 32 bits");
  end

endmodule

// File: spatz_controller.sv
`timescale 1ns/1ns
`include "spatz_params.svh"

/*
 * Issue stage: decode, register scoreboard, tag counter,
 * request slot towards the units and ordered completion queue
 */
module spatz_controller (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Issue
  input  logic                  x_issue_valid_i,
  output logic                  x_issue_ready_o,
  input  spatz_pkg::op_e        x_issue_op_i,
  input  spatz_pkg::vreg_addr_t x_issue_vd_i,
  input  spatz_pkg::vreg_addr_t x_issue_vs1_i,
  input  spatz_pkg::vreg_addr_t x_issue_vs2_i,
  input  spatz_pkg::addr_t      x_issue_addr_i,
  // Result
  output logic                  x_result_valid_o,
  input  logic                  x_result_ready_i,
  output spatz_pkg::tag_t       x_result_tag_o,
  // Shared request bus
  output logic                  req_valid_o,
  output spatz_pkg::op_e        req_op_o,
  output spatz_pkg::vreg_addr_t req_vd_o,
  output spatz_pkg::vreg_addr_t req_vs1_o,
  output spatz_pkg::vreg_addr_t req_vs2_o,
  output spatz_pkg::addr_t      req_addr_o,
  output spatz_pkg::tag_t       req_tag_o,
  // Unit handshakes and completions
  input  logic                  vfu_req_ready_i,
  input  logic                  vlsu_req_ready_i,
  input  logic                  vfu_rsp_valid_i,
  input  spatz_pkg::tag_t       vfu_rsp_tag_i,
  input  spatz_pkg::vreg_addr_t vfu_rsp_vd_i,
  input  logic                  vlsu_rsp_valid_i,
  input  spatz_pkg::tag_t       vlsu_rsp_tag_i,
  input  spatz_pkg::vreg_addr_t vlsu_rsp_vd_i
);
  import spatz_pkg::*;

  localparam int DEPTH = `SPATZ_RESULT_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [`SPATZ_NR_VREGS-1:0] pend_q;
  logic [`SPATZ_NR_VREGS-1:0] pend_d;
  tag_t                       tag_q;
  logic                       uses_vs;
  logic                       hazard;
  logic                       issue_fire;
  logic                       lsu_op;
  logic                       req_accept;
  logic [1:0]                 n_done;
  logic                       pop;
  logic [CNT_W-1:0]           inflight_q;
  logic [CNT_W-1:0]           cnt_q;
  logic [CNT_W:0]             occupancy;
  tag_t                       queue_q [DEPTH];
  logic [PTR_W-1:0]           wr_ptr_q;
  logic [PTR_W-1:0]           rd_ptr_q;
  logic [PTR_W-1:0]           vlsu_slot;

  ////////////////////
  // Decode and stall
  ////////////////////

  // Stores read the register in the vd field, so vd is always checked
  assign uses_vs   = (x_issue_op_i == VADD) || (x_issue_op_i == VMUL);
  assign hazard    = pend_q[x_issue_vd_i] ||
                     (uses_vs && (pend_q[x_issue_vs1_i] || pend_q[x_issue_vs2_i]));
  assign occupancy = {1'b0, cnt_q} + {1'b0, inflight_q};

  assign x_issue_ready_o = !req_valid_o && !hazard && (occupancy < (CNT_W+1)'(DEPTH));
  assign issue_fire      = x_issue_valid_i && x_issue_ready_o;

  assign lsu_op     = (req_op_o == VLOAD) || (req_op_o == VSTORE);
  assign req_accept = req_valid_o && (lsu_op ? vlsu_req_ready_i : vfu_req_ready_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_valid_o <= 1'b0;
      tag_q       <= '0;
    end else if (issue_fire) begin
      req_valid_o <= 1'b1;
      tag_q       <= tag_q + 1'b1;
    end else if (req_accept) begin
      req_valid_o <= 1'b0;
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    if (issue_fire) begin
      req_op_o   <= x_issue_op_i;
      req_vd_o   <= x_issue_vd_i;
      req_vs1_o  <= x_issue_vs1_i;
      req_vs2_o  <= x_issue_vs2_i;
      req_addr_o <= x_issue_addr_i;
      req_tag_o  <= tag_q;
    end
  end

  // Pending writes are set at issue and cleared by completion
  always_comb begin
    pend_d = pend_q;
    if (vfu_rsp_valid_i) begin
      pend_d[vfu_rsp_vd_i] = 1'b0;
    end
    if (vlsu_rsp_valid_i) begin
      pend_d[vlsu_rsp_vd_i] = 1'b0;
    end
    if (issue_fire) begin
      pend_d[x_issue_vd_i] = 1'b1;
    end
  end

  ////////////////////
  // Completion queue
  ////////////////////

  assign n_done    = {1'b0, vfu_rsp_valid_i} + {1'b0, vlsu_rsp_valid_i};
  assign pop       = x_result_valid_o && x_result_ready_i;
  // VFU goes first when both finish together
  assign vlsu_slot = wr_ptr_q + PTR_W'(vfu_rsp_valid_i);

  assign x_result_valid_o = (cnt_q != '0);
  assign x_result_tag_o   = queue_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q     <= '0;
      inflight_q <= '0;
      cnt_q      <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
    end else begin
      pend_q     <= pend_d;
      inflight_q <= inflight_q + CNT_W'(issue_fire) - CNT_W'(n_done);
      cnt_q      <= cnt_q + CNT_W'(n_done) - CNT_W'(pop);
      wr_ptr_q   <= wr_ptr_q + PTR_W'(n_done);
      rd_ptr_q   <= rd_ptr_q + PTR_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (vfu_rsp_valid_i) begin
      queue_q[wr_ptr_q] <= vfu_rsp_tag_i;
    end
    if (vlsu_rsp_valid_i) begin
      queue_q[vlsu_slot] <= vlsu_rsp_tag_i;
    end
  end

  // A waiting request keeps its destination reserved
  a_req_dest_pending: assert property (@(posedge clk_i) disable iff (rst_i)
    req_valid_o |-> pend_q[req_vd_o]);

  // Units only complete what was issued to them
  a_rsp_was_pending: assert property (@(posedge clk_i) disable iff (rst_i)
    (vfu_rsp_valid_i |-> pend_q[vfu_rsp_vd_i]) and
    (vlsu_rsp_valid_i |-> pend_q[vlsu_rsp_vd_i]));

endmodule

// File: spatz_params.svh
/*
 * Sizing macros for the vector coprocessor: register file geometry,
 * element width, tag width, result queue depth and memory addressing
 */
`ifndef SPATZ_PARAMS_SVH
`define SPATZ_PARAMS_SVH

// Register file geometry, VLEN must be a power of two
`define SPATZ_NR_VREGS 8
`define SPATZ_VLEN 4
`define SPATZ_ELEN 16

// Tags wrap at 2**TAG_W, queue depth is a power of two
`define SPATZ_TAG_W 4
`define SPATZ_RESULT_DEPTH 4

// Memory is addressed per element
`define SPATZ_ADDR_W 8

`endif

// File: spatz_pkg.sv
/*
 * Shared types of the vector coprocessor: operation codes, register
 * addresses, elements, whole vectors, byte enables, tags, addresses
 */
`include "spatz_params.svh"

package spatz_pkg;

  // Operation code on the issue and request buses
  typedef enum logic [1:0] {
    VADD   = 2'd0,
    VMUL   = 2'd1,
    VLOAD  = 2'd2,
    VSTORE = 2'd3
  } op_e;

  // Register index
  typedef logic [$clog2(`SPATZ_NR_VREGS)-1:0] vreg_addr_t;

  // One element and one whole register
  typedef logic [`SPATZ_ELEN-1:0] elem_t;
  typedef elem_t [`SPATZ_VLEN-1:0] vreg_data_t;

  // One write enable per element
  typedef logic [`SPATZ_VLEN-1:0] vreg_be_t;

  typedef logic [`SPATZ_TAG_W-1:0] tag_t;
  typedef logic [`SPATZ_ADDR_W-1:0] addr_t;

endpackage

// File: spatz_vfu.sv
`timescale 1ns/1ns
`include "spatz_params.svh"

/*
 * Functional unit: element-wise add and multiply,
 * one instruction at a time
 */
module spatz_vfu (
  input  logic                        clk_i,
  input  logic                        rst_i,
  // Request
  input  logic                        req_valid_i,
  input  spatz_pkg::op_e              req_op_i,
  input  spatz_pkg::vreg_addr_t       req_vd_i,
  input  spatz_pkg::vreg_addr_t       req_vs1_i,
  input  spatz_pkg::vreg_addr_t       req_vs2_i,
  input  spatz_pkg::tag_t             req_tag_i,
  output logic                        req_ready_o,
  // Completion
  output logic                        rsp_valid_o,
  output spatz_pkg::tag_t             rsp_tag_o,
  output spatz_pkg::vreg_addr_t       rsp_vd_o,
  // Register file
  output spatz_pkg::vreg_addr_t       vrf_waddr_o,
  output spatz_pkg::vreg_data_t       vrf_wdata_o,
  output spatz_pkg::vreg_be_t         vrf_wbe_o,
  output spatz_pkg::vreg_addr_t [1:0] vrf_raddr_o,
  output logic                  [1:0] vrf_re_o,
  input  spatz_pkg::vreg_data_t [1:0] vrf_rdata_i
);
  import spatz_pkg::*;

  typedef enum logic [1:0] {IDLE, READ, WRITE} state_e;

  state_e     state_q;
  logic       accept;
  op_e        op_q;
  vreg_addr_t vd_q;
  vreg_addr_t vs1_q;
  vreg_addr_t vs2_q;
  tag_t       tag_q;

  assign req_ready_o = (state_q == IDLE);
  assign accept      = req_valid_i && req_ready_o &&
                       ((req_op_i == VADD) || (req_op_i == VMUL));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (accept) state_q <= READ;
        READ:    state_q <= WRITE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q  <= req_op_i;
      vd_q  <= req_vd_i;
      vs1_q <= req_vs1_i;
      vs2_q <= req_vs2_i;
      tag_q <= req_tag_i;
    end
  end

  // Both sources are read together
  assign vrf_re_o    = {2{state_q == READ}};
  assign vrf_raddr_o = {vs2_q, vs1_q};

  // Results wrap to the element width
  always_comb begin
    for (int i = 0; i < `SPATZ_VLEN; i++) begin
      if (op_q == VMUL) begin
        vrf_wdata_o[i] = vrf_rdata_i[0][i] * vrf_rdata_i[1][i];
      end else begin
        vrf_wdata_o[i] = vrf_rdata_i[0][i] + vrf_rdata_i[1][i];
      end
    end
  end

  assign vrf_waddr_o = vd_q;
  assign vrf_wbe_o   = (state_q == WRITE) ? '1 : '0;
  assign rsp_valid_o = (state_q == WRITE);
  assign rsp_tag_o   = tag_q;
  assign rsp_vd_o    = vd_q;

endmodule

// File: spatz_vlsu.sv
`timescale 1ns/1ns
`include "spatz_params.svh"

/*
 * Load/store unit: moves whole vectors one element at a time
 * over a single memory port
 */
module spatz_vlsu (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Request
  input  logic                  req_valid_i,
  input  spatz_pkg::op_e        req_op_i,
  input  spatz_pkg::vreg_addr_t req_vd_i,
  input  spatz_pkg::addr_t      req_addr_i,
  input  spatz_pkg::tag_t       req_tag_i,
  output logic                  req_ready_o,
  // Completion
  output logic                  rsp_valid_o,
  output spatz_pkg::tag_t       rsp_tag_o,
  output spatz_pkg::vreg_addr_t rsp_vd_o,
  // Register file
  output spatz_pkg::vreg_addr_t vrf_waddr_o,
  output spatz_pkg::vreg_data_t vrf_wdata_o,
  output spatz_pkg::vreg_be_t   vrf_wbe_o,
  output spatz_pkg::vreg_addr_t vrf_raddr_o,
  output logic                  vrf_re_o,
  input  spatz_pkg::vreg_data_t vrf_rdata_i,
  // Memory
  output logic                  x_mem_valid_o,
  input  logic                  x_mem_ready_i,
  output spatz_pkg::addr_t      x_mem_addr_o,
  output logic                  x_mem_we_o,
  output spatz_pkg::elem_t      x_mem_wdata_o,
  input  logic                  x_mem_result_valid_i,
  input  spatz_pkg::elem_t      x_mem_result_i,
  output logic                  x_mem_finished_o
);
  import spatz_pkg::*;

  localparam int VLEN  = `SPATZ_VLEN;
  localparam int IDX_W = $clog2(VLEN);
  localparam int CNT_W = IDX_W + 1;

  typedef enum logic [2:0] {IDLE, LOAD, ST_READ, STORE, DONE} state_e;

  state_e           state_q;
  logic             accept;
  logic             req_left;
  logic             mem_fire;
  logic [CNT_W-1:0] req_cnt_q;
  logic [CNT_W-1:0] res_cnt_q;
  logic             is_load_q;
  vreg_addr_t       vd_q;
  addr_t            base_q;
  tag_t             tag_q;
  vreg_data_t       vec_q;

  assign req_ready_o = (state_q == IDLE);
  assign accept      = req_valid_i && req_ready_o &&
                       ((req_op_i == VLOAD) || (req_op_i == VSTORE));

  ////////////////////
  // Memory requests
  ////////////////////

  assign req_left      = (req_cnt_q != CNT_W'(VLEN));
  assign x_mem_valid_o = ((state_q == LOAD) || (state_q == STORE)) && req_left;
  assign mem_fire      = x_mem_valid_o && x_mem_ready_i;
  assign x_mem_addr_o  = base_q + addr_t'(req_cnt_q);
  assign x_mem_we_o    = (state_q == STORE);
  // Source vector stays on the read port for the whole store
  assign x_mem_wdata_o = vrf_rdata_i[req_cnt_q[IDX_W-1:0]];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= IDLE;
      req_cnt_q <= '0;
      res_cnt_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q   <= (req_op_i == VLOAD) ? LOAD : ST_READ;
            req_cnt_q <= '0;
            res_cnt_q <= '0;
          end
        end
        LOAD: begin
          if (mem_fire) begin
            req_cnt_q <= req_cnt_q + 1'b1;
          end
          if (x_mem_result_valid_i) begin
            res_cnt_q <= res_cnt_q + 1'b1;
            if (res_cnt_q == CNT_W'(VLEN - 1)) state_q <= DONE;
          end
        end
        ST_READ: state_q <= STORE;
        STORE: begin
          if (mem_fire) begin
            req_cnt_q <= req_cnt_q + 1'b1;
            if (req_cnt_q == CNT_W'(VLEN - 1)) state_q <= DONE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Instruction fields and load assembly
  always_ff @(posedge clk_i) begin
    if (accept) begin
      is_load_q <= (req_op_i == VLOAD);
      vd_q      <= req_vd_i;
      base_q    <= req_addr_i;
      tag_q     <= req_tag_i;
    end
    if ((state_q == LOAD) && x_mem_result_valid_i) begin
      vec_q[res_cnt_q[IDX_W-1:0]] <= x_mem_result_i;
    end
  end

  ////////////////////
  // Register file and completion
  ////////////////////

  // Stores take their data from the register in the vd field
  assign vrf_re_o    = (state_q == ST_READ);
  assign vrf_raddr_o = vd_q;

  assign vrf_waddr_o      = vd_q;
  assign vrf_wdata_o      = vec_q;
  assign vrf_wbe_o        = ((state_q == DONE) && is_load_q) ? '1 : '0;
  assign rsp_valid_o      = (state_q == DONE);
  assign rsp_tag_o        = tag_q;
  assign rsp_vd_o         = vd_q;
  assign x_mem_finished_o = (state_q == DONE);

  a_result_expected: assert property (@(posedge clk_i) disable iff (rst_i)
    x_mem_result_valid_i |-> (state_q == LOAD) && (res_cnt_q < req_cnt_q));

endmodule

// File: spatz_vrf.sv
`timescale 1ns/1ns
`include "spatz_params.svh"

/*
 * Vector register file with per-element write enables
 * and registered read ports
 */
module spatz_vrf #(
  parameter int NR_WRITE_PORTS = 2,
  parameter int NR_READ_PORTS  = 3
) (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  // Write ports
  input  spatz_pkg::vreg_addr_t [NR_WRITE_PORTS-1:0] waddr_i,
  input  spatz_pkg::vreg_data_t [NR_WRITE_PORTS-1:0] wdata_i,
  input  spatz_pkg::vreg_be_t   [NR_WRITE_PORTS-1:0] wbe_i,
  // Read ports
  input  spatz_pkg::vreg_addr_t [NR_READ_PORTS-1:0]  raddr_i,
  input  logic                  [NR_READ_PORTS-1:0]  re_i,
  output spatz_pkg::vreg_data_t [NR_READ_PORTS-1:0]  rdata_o
);
  import spatz_pkg::*;

  vreg_data_t mem_q [`SPATZ_NR_VREGS];

  // Element-wise writes, the scoreboard keeps ports apart
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NR_WRITE_PORTS; w++) begin
      for (int e = 0; e < `SPATZ_VLEN; e++) begin
        if (wbe_i[w][e]) begin
          mem_q[waddr_i[w]][e] <= wdata_i[w][e];
        end
      end
    end
  end

  // Read data holds until the next read on the same port
  always_ff @(posedge clk_i) begin
    for (int r = 0; r < NR_READ_PORTS; r++) begin
      if (re_i[r]) begin
        rdata_o[r] <= mem_q[raddr_i[r]];
      end
    end
  end

  a_no_write_clash: assert property (@(posedge clk_i) disable iff (rst_i)
    ((|wbe_i[0]) && (|wbe_i[1])) |-> (waddr_i[0] != waddr_i[1]));

endmodule

// File: tb_spatz.sv
`timescale 1ns/1ns
`include "spatz_params.svh"

/*
 * Directed testbench for the vector coprocessor: memory model,
 * result sink, issue and check tasks, closing summary
 */
module tb_spatz;
  import spatz_pkg::*;

  localparam int TIMEOUT = 1000;

  logic       clk_i;
  logic       rst_i;
  logic       x_issue_valid_i;
  logic       x_issue_ready_o;
  op_e        x_issue_op_i;
  vreg_addr_t x_issue_vd_i;
  vreg_addr_t x_issue_vs1_i;
  vreg_addr_t x_issue_vs2_i;
  addr_t      x_issue_addr_i;
  logic       x_result_valid_o;
  logic       x_result_ready_i;
  tag_t       x_result_tag_o;
  logic       x_mem_valid_o;
  logic       x_mem_ready_i;
  addr_t      x_mem_addr_o;
  logic       x_mem_we_o;
  elem_t      x_mem_wdata_o;
  logic       x_mem_result_valid_i;
  elem_t      x_mem_result_i;
  logic       x_mem_finished_o;

  elem_t  mem [256];
  integer seed = 68625;
  integer rnd;
  int     value_errors;
  int     other_errors;
  int     mem_ops;
  int     finished_pulses;
  int     stall_cycles;
  logic   stall_request;
  tag_t   next_tag;
  tag_t   issued_tags [$];
  tag_t   seen_tags [$];

  spatz dut0 (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .x_issue_valid_i     (x_issue_valid_i),
    .x_issue_ready_o     (x_issue_ready_o),
    .x_issue_op_i        (x_issue_op_i),
    .x_issue_vd_i        (x_issue_vd_i),
    .x_issue_vs1_i       (x_issue_vs1_i),
    .x_issue_vs2_i       (x_issue_vs2_i),
    .x_issue_addr_i      (x_issue_addr_i),
    .x_result_valid_o    (x_result_valid_o),
    .x_result_ready_i    (x_result_ready_i),
    .x_result_tag_o      (x_result_tag_o),
    .x_mem_valid_o       (x_mem_valid_o),
    .x_mem_ready_i       (x_mem_ready_i),
    .x_mem_addr_o        (x_mem_addr_o),
    .x_mem_we_o          (x_mem_we_o),
    .x_mem_wdata_o       (x_mem_wdata_o),
    .x_mem_result_valid_i(x_mem_result_valid_i),
    .x_mem_result_i      (x_mem_result_i),
    .x_mem_finished_o    (x_mem_finished_o)
  );

  always #10 clk_i = ~clk_i;

  ////////////////////
  // Memory model and result sink
  ////////////////////

  // One draw per cycle feeds both ready signals
  always @(posedge clk_i) begin
    rnd = $random(seed);
    memory_step(rnd);
    collect_result(rnd);
  end

  // Loads answer in the cycle after acceptance and stores update the array
  task automatic memory_step(input integer r);
    x_mem_result_valid_i <= 1'b0;
    if (x_mem_valid_o && x_mem_ready_i) begin
      if (x_mem_we_o) begin
        mem[x_mem_addr_o] = x_mem_wdata_o;
      end else begin
        x_mem_result_valid_i <= 1'b1;
        x_mem_result_i       <= mem[x_mem_addr_o];
      end
    end
    if (x_mem_finished_o) begin
      finished_pulses++;
    end
    x_mem_ready_i <= (r[1:0] != 2'b00);
  endtask

  task automatic collect_result(input integer r);
    if (x_result_valid_o && x_result_ready_i) begin
      seen_tags.push_back(x_result_tag_o);
    end
    if (stall_request) begin
      stall_cycles = 8 + int'(r[7:4]);
    end
    if (stall_cycles > 0) begin
      stall_cycles--;
      x_result_ready_i <= 1'b0;
    end else begin
      x_result_ready_i <= (r[3:2] != 2'b00);
    end
  endtask

  ////////////////////
  // Helpers
  ////////////////////

  function automatic elem_t fill_value(input addr_t a);
    return {~a, a};
  endfunction

  // Random contents for one vector in memory
  task automatic fill_random(input addr_t base);
    @(negedge clk_i);
    for (int i = 0; i < `SPATZ_VLEN; i++) begin
      mem[base + addr_t'(i)] = elem_t'($random(seed));
    end
    @(posedge clk_i);
  endtask

  task automatic issue(input op_e op, input vreg_addr_t vd, vs1, vs2, input addr_t addr);
    bit done;
    done = 1'b0;
    x_issue_valid_i <= 1'b1;
    x_issue_op_i    <= op;
    x_issue_vd_i    <= vd;
    x_issue_vs1_i   <= vs1;
    x_issue_vs2_i   <= vs2;
    x_issue_addr_i  <= addr;
    for (int n = 0; n < TIMEOUT && !done; n++) begin
      @(posedge clk_i);
      done = x_issue_ready_o;
    end
    x_issue_valid_i <= 1'b0;
    assert (done) else begin
      other_errors++;
      $display("Timeout: a %s instruction was never accepted", op.name());
    end
    if (done) begin
      issued_tags.push_back(next_tag);
      next_tag++;
      if (op == VLOAD || op == VSTORE) begin
        mem_ops++;
      end
    end
  endtask

  task automatic wait_idle();
    bit done;
    done = 1'b0;
    for (int n = 0; n < TIMEOUT && !done; n++) begin
      @(posedge clk_i);
      done = (seen_tags.size() == issued_tags.size()) && !x_result_valid_o;
    end
    assert (done) else begin
      other_errors++;
      $display("Timeout: not every issued instruction reported completion");
    end
  endtask

  // Each issued tag exactly once in any order
  task automatic check_tags();
    int hits;
    foreach (issued_tags[i]) begin
      hits = 0;
      foreach (seen_tags[j]) begin
        if (seen_tags[j] == issued_tags[i]) hits++;
      end
      assert (hits == 1) else begin
        value_errors++;
        $display("Fail at %0t ns: x_result_tag_o count of tag %0d is %0d, expected 1",
                 $time, issued_tags[i], hits);
      end
    end
    issued_tags.delete();
    seen_tags.delete();
  endtask

  task automatic check_mem(input addr_t addr, input elem_t expected);
    assert (mem[addr] === expected) else begin
      value_errors++;
      $display("Fail at %0t ns: mem[%0d] is %h, expected %h",
               $time, addr, mem[addr], expected);
    end
  endtask

  task automatic check_bit(input string name, input logic value, input logic expected);
    assert (value === expected) else begin
      value_errors++;
      $display("Fail at %0t ns: %s is %b, expected %b", $time, name, value, expected);
    end
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset_values();
    check_bit("x_result_valid_o", x_result_valid_o, 1'b0);
    check_bit("x_mem_valid_o", x_mem_valid_o, 1'b0);
    check_bit("x_mem_finished_o", x_mem_finished_o, 1'b0);
    check_bit("x_issue_ready_o", x_issue_ready_o, 1'b1);
  endtask

  task automatic test_load_store();
    issue(VLOAD, 3'd1, 3'd0, 3'd0, 8'd0);
    issue(VSTORE, 3'd1, 3'd0, 3'd0, 8'd100);
    wait_idle();
    check_tags();
    for (int i = 0; i < `SPATZ_VLEN; i++) begin
      check_mem(addr_t'(100 + i), fill_value(addr_t'(i)));
    end
  endtask

  task automatic test_arith();
    logic [16:0] sum;
    logic [31:0] prod;
    fill_random(8'd20);
    fill_random(8'd24);
    issue(VLOAD, 3'd1, 3'd0, 3'd0, 8'd20);
    issue(VLOAD, 3'd2, 3'd0, 3'd0, 8'd24);
    issue(VADD, 3'd3, 3'd1, 3'd2, 8'd0);
    issue(VMUL, 3'd4, 3'd1, 3'd2, 8'd0);
    issue(VSTORE, 3'd3, 3'd0, 3'd0, 8'd120);
    issue(VSTORE, 3'd4, 3'd0, 3'd0, 8'd124);
    wait_idle();
    check_tags();
    for (int i = 0; i < `SPATZ_VLEN; i++) begin
      sum  = {1'b0, mem[20 + i]} + {1'b0, mem[24 + i]};
      prod = {16'h0, mem[20 + i]} * {16'h0, mem[24 + i]};
      check_mem(addr_t'(120 + i), sum[15:0]);
      check_mem(addr_t'(124 + i), prod[15:0]);
    end
  endtask

  // VADD right behind the load of its source
  task automatic test_hazard();
    logic [16:0] sum;
    fill_random(8'd40);
    fill_random(8'd44);
    issue(VLOAD, 3'd5, 3'd0, 3'd0, 8'd40);
    wait_idle();
    check_tags();
    issue(VLOAD, 3'd5, 3'd0, 3'd0, 8'd44);
    issue(VADD, 3'd6, 3'd5, 3'd5, 8'd0);
    issue(VSTORE, 3'd6, 3'd0, 3'd0, 8'd140);
    wait_idle();
    check_tags();
    for (int i = 0; i < `SPATZ_VLEN; i++) begin
      sum = {1'b0, mem[44 + i]} + {1'b0, mem[44 + i]};
      check_mem(addr_t'(140 + i), sum[15:0]);
    end
  endtask

  // Two rounds carry the tag counter past its wrap
  task automatic test_overlap();
    logic [31:0] prod;
    addr_t       src;
    addr_t       dst;
    for (int r = 0; r < 2; r++) begin
      src = addr_t'(60 + 8 * r);
      dst = addr_t'(160 + 8 * r);
      fill_random(src);
      stall_request <= 1'b1;
      @(posedge clk_i);
      stall_request <= 1'b0;
      issue(VMUL, 3'd7, 3'd1, 3'd2, 8'd0);
      issue(VLOAD, 3'd0, 3'd0, 3'd0, src);
      issue(VSTORE, 3'd7, 3'd0, 3'd0, dst);
      issue(VSTORE, 3'd0, 3'd0, 3'd0, dst + 8'd4);
      wait_idle();
      check_tags();
      for (int i = 0; i < `SPATZ_VLEN; i++) begin
        prod = {16'h0, mem[20 + i]} * {16'h0, mem[24 + i]};
        check_mem(dst + addr_t'(i), prod[15:0]);
        check_mem(dst + addr_t'(4 + i), mem[src + addr_t'(i)]);
      end
    end
  endtask

  initial begin
    clk_i                = 1'b0;
    rst_i                = 1'b1;
    x_issue_valid_i      = 1'b0;
    x_issue_op_i         = VADD;
    x_issue_vd_i         = '0;
    x_issue_vs1_i        = '0;
    x_issue_vs2_i        = '0;
    x_issue_addr_i       = '0;
    x_result_ready_i     = 1'b0;
    x_mem_ready_i        = 1'b0;
    x_mem_result_valid_i = 1'b0;
    x_mem_result_i       = '0;
    stall_request        = 1'b0;
    stall_cycles         = 0;
    next_tag             = '0;
    value_errors         = 0;
    other_errors         = 0;
    mem_ops              = 0;
    finished_pulses      = 0;
    for (int a = 0; a < 256; a++) begin
      mem[a] = fill_value(addr_t'(a));
    end

    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);

    test_reset_values();
    test_load_store();
    test_arith();
    test_hazard();
    test_overlap();

    assert (finished_pulses == mem_ops) else begin
      value_errors++;
      $display("Fail at %0t ns: x_mem_finished_o pulses %0d, expected %0d",
               $time, finished_pulses, mem_ops);
    end

    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
